/* verif/renameTests.mem */
// op count/mask checkpoint tag0 tag1 tag2 tag3 expectedFreeCount
// op 1 alloc, 2 release, 3 recover, 4 check count, 5 starved alloc, 6 alloc with held grant, ff end
04 00 00 00 00 00 00 20
01 04 00 10 11 12 13 1c
01 01 00 14 00 00 00 1b
01 03 00 15 16 17 00 18
01 02 00 18 19 00 00 16
02 0a 00 00 11 00 13 18
01 04 00 1a 1b 1c 1d 14
01 04 00 1e 1f 20 21 10
01 04 00 22 23 24 25 0c
01 04 00 26 27 28 29 08
01 04 00 2a 2b 2c 2d 04
01 04 00 2e 2f 11 13 00
05 02 00 00 00 00 00 00
02 0f 00 10 12 14 15 04
01 02 00 10 12 00 00 02
02 0f 00 16 17 18 19 06
01 02 01 14 15 00 00 04
01 03 00 16 17 18 00 01
02 03 00 1a 1b 00 00 03
03 00 00 00 00 00 00 08
01 02 00 14 15 00 00 06
03 00 00 00 00 00 00 06
06 02 00 16 17 00 00 04
01 02 00 18 19 00 00 02
04 00 00 00 00 00 00 02
ff 00 00 00 00 00 00 00

/* compile.f */
hw/renameCfgPkg.sv
hw/renameMsgPkg.sv
hw/fourPhaseSink.sv
hw/fourPhaseSource.sv
hw/freeListRam.sv
hw/specFreeList.sv
hw/renameUnit.sv
verif/renameUnitTb.sv

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --top-module renameUnitTb -f compile.f -o renameSim
./obj_dir/renameSim | tee sim.log

if grep -qx "Test passed" sim.log
then
  echo "simulation run succeeded"
  exit 0
fi
echo "simulation run reported errors, see sim.log"
exit 1

/* verif/renameUnitTb.sv */
// testbench for the rename allocator that replays an operation list and checks grants and free count
module renameUnitTb;

  import renameCfgPkg::*;
  import renameMsgPkg::*;

  localparam int MaxOps = 64;
  localparam int ListSize = 48 - 16;  // physical minus architectural registers at the default sizes
  localparam int OpAlloc = 1;
  localparam int OpRelease = 2;
  localparam int OpRecover = 3;
  localparam int OpCheckCount = 4;
  localparam int OpStarve = 5;  // alloc left pending while too few tags are free
  localparam int OpHold = 6;  // alloc whose grant is held while a second alloc waits

  logic        clk;
  logic        reset;
  logic        allocReq;
  allocReq_t   allocData;
  logic        allocAck;
  logic        relReq;
  releaseReq_t relData;
  logic        relAck;
  logic        recover;
  logic        grantReq;
  grant_t      grantData;
  logic        grantAck;
  logic [5:0]  freeCount;

  logic [7:0] testMem [MaxOps*8];
  grant_t     grantLog [$];
  int         numOps;
  int         errorCount;
  int         checkCount;
  bit         holdGrant;
  int         opCode;
  int         opCount;
  int         opFlag;
  int         opExpect;
  int         opTags [MaxLanes];
  int         expectHead;  // list index of the next tag to be granted
  int         savedHead;
  bit         savedValid;

  renameUnit dut0 (
    .clk        (clk),
    .reset      (reset),
    .allocReq_i (allocReq),
    .allocData_i(allocData),
    .allocAck_o (allocAck),
    .relReq_i   (relReq),
    .relData_i  (relData),
    .relAck_o   (relAck),
    .recover_i  (recover),
    .grantReq_o (grantReq),
    .grantData_o(grantData),
    .grantAck_i (grantAck),
    .freeCount_o(freeCount)
  );

  initial
  begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  task automatic check(string name, logic [63:0] expected, logic [63:0] actual);
    checkCount++;
    if (expected !== actual)
    begin
      errorCount++;
      $display("[FAIL] t=%0t %s expected %0h actual %0h", $time, name, expected, actual);
    end
  endtask

  // only the low opCount lanes carry tags
  task automatic checkGrant(grant_t g);
    logic [MaxLanes-1:0] mask;
    mask = '0;
    for (int l = 0; l < MaxLanes; l++)
    begin
      if (l < opCount)
      begin
        mask[l] = 1'b1;
        check($sformatf("grantData_o.tags[%0d]", l), 64'(opTags[l]), 64'(g.tags[l]));
      end
    end
    check("grantData_o.valid", 64'(mask), 64'(g.valid));
    check("grantData_o.headIdx", 64'(expectHead), 64'(g.headIdx));
    if (allocData.takeCheckpoint)
    begin
      savedHead = expectHead;  // head before this request's pop
      savedValid = 1'b1;
    end
    expectHead = (expectHead + opCount) % ListSize;
  endtask

  task automatic popGrant(output grant_t g);
    while (grantLog.size() == 0)
      @(negedge clk);
    g = grantLog.pop_front();
  endtask

  task automatic raiseAlloc(int takeCp);
    allocData.count = LaneCountBits'(opCount);
    allocData.takeCheckpoint = takeCp[0];
    allocReq = 1'b1;
  endtask

  // a request still pending from an earlier line is finished rather than raised again
  task automatic sendAlloc();
    if (!allocReq)
      raiseAlloc(opFlag);
    @(negedge clk);
    while (!allocAck)
      @(negedge clk);
    check("freeCount_o", 64'(opExpect), 64'(freeCount));
    allocReq = 1'b0;
    @(negedge clk);
    while (allocAck)
      @(negedge clk);
  endtask

  task automatic sendRelease();
    relData.valid = MaxLanes'(opCount);
    for (int l = 0; l < MaxLanes; l++)
      relData.tags[l] = physTag_t'(opTags[l]);
    relReq = 1'b1;
    @(negedge clk);
    while (!relAck)
      @(negedge clk);
    check("freeCount_o", 64'(opExpect), 64'(freeCount));
    relReq = 1'b0;
    @(negedge clk);
    while (relAck)
      @(negedge clk);
  endtask

  task automatic starveAlloc();
    raiseAlloc(opFlag);
    repeat (6)
    begin
      @(negedge clk);
      check("allocAck_o", 64'(0), 64'(allocAck));
      check("grantReq_o", 64'(0), 64'(grantReq));
    end
    check("freeCount_o", 64'(opExpect), 64'(freeCount));
  endtask

  task automatic holdAlloc();
    grant_t held;
    grant_t g;
    holdGrant = 1'b1;
    sendAlloc();
    while (!grantReq)
      @(negedge clk);
    held = grantData;
    checkGrant(held);
    raiseAlloc(0);  // the same count again, finished by the next line
    repeat (6)
    begin
      @(negedge clk);
      check("allocAck_o", 64'(0), 64'(allocAck));
      check("grantReq_o", 64'(1), 64'(grantReq));
      check("grantData_o", 64'(held), 64'(grantData));
    end
    @(posedge clk);
    holdGrant = 1'b0;
    popGrant(g);
    check("grantData_o", 64'(held), 64'(g));
  endtask

  // grant consumer, acks after a random 0 to 3 cycles unless told to hold
  initial
  begin : grantResponder
    int delay;
    grantAck = 1'b0;
    delay = int'($urandom(32'hd087));
    forever
    begin
      @(negedge clk);
      if (grantReq && !holdGrant)
      begin
        delay = int'($urandom % 4);
        repeat (delay) @(negedge clk);
        grantLog.push_back(grantData);
        grantAck = 1'b1;
        while (grantReq)
          @(negedge clk);
        grantAck = 1'b0;
      end
    end
  end

  initial
  begin : watchdog
    @(negedge clk);
    repeat (numOps * 40 + 100) @(posedge clk);
    $display("the run timed out after %0d cycles with operations still open", numOps * 40 + 100);
    $display("Test failed");
    $finish;
  end

  initial
  begin : mainSequence
    grant_t g;
    reset = 1'b1;
    allocReq = 1'b0;
    allocData = '0;
    relReq = 1'b0;
    relData = '0;
    recover = 1'b0;
    holdGrant = 1'b0;
    errorCount = 0;
    checkCount = 0;
    expectHead = 0;
    savedHead = 0;
    savedValid = 1'b0;
    for (int k = 0; k < MaxOps * 8; k++)
      testMem[k] = 8'hff;
    $readmemh("verif/renameTests.mem", testMem);
    numOps = 0;
    while (numOps < MaxOps && testMem[numOps*8] != 8'hff)
      numOps++;
    if (numOps == 0)
    begin
      errorCount++;
      $display("no operations were loaded from the test file");
    end
    repeat (2) @(negedge clk);
    reset = 1'b0;
    check("allocAck_o", 64'(0), 64'(allocAck));
    check("relAck_o", 64'(0), 64'(relAck));
    check("grantReq_o", 64'(0), 64'(grantReq));
    for (int i = 0; i < numOps; i++)
    begin
      opCode = int'(testMem[i*8]);
      opCount = int'(testMem[i*8+1]);
      opFlag = int'(testMem[i*8+2]);
      for (int l = 0; l < MaxLanes; l++)
        opTags[l] = int'(testMem[i*8+3+l]);
      opExpect = int'(testMem[i*8+7]);
      case (opCode)
        OpAlloc:
        begin
          sendAlloc();
          popGrant(g);
          checkGrant(g);
        end
        OpRelease:
          sendRelease();
        OpRecover:
        begin
          recover = 1'b1;
          @(negedge clk);
          recover = 1'b0;
          check("freeCount_o", 64'(opExpect), 64'(freeCount));
          if (savedValid)
            expectHead = savedHead;  // head moves back only with a live checkpoint
          savedValid = 1'b0;
        end
        OpCheckCount:
          check("freeCount_o", 64'(opExpect), 64'(freeCount));
        OpStarve:
          starveAlloc();
        OpHold:
          holdAlloc();
        default:
        begin
          errorCount++;
          $display("line %0d of the test file has an unknown opcode %0h", i, opCode);
        end
      endcase
    end
    $display("%0d checks, %0d errors", checkCount, errorCount);
    if (errorCount == 0)
      $display("Test passed");
    else
      $display("Test failed");
    $finish;
  end

endmodule

/* hw/renameUnit.sv */
// rename allocator top: handshake receivers and sender around the speculative free list
module renameUnit #(
  parameter int  NumPhysRegs = 48,
  parameter int  NumArchRegs = 16,
  localparam int CountBits = $clog2(NumPhysRegs - NumArchRegs + 1)
) (
  input  logic                      clk,
  input  logic                      reset,
  input  logic                      allocReq_i,
  input  renameMsgPkg::allocReq_t   allocData_i,
  output logic                      allocAck_o,
  input  logic                      relReq_i,
  input  renameMsgPkg::releaseReq_t relData_i,
  output logic                      relAck_o,
  input  logic                      recover_i,
  output logic                      grantReq_o,
  output renameMsgPkg::grant_t      grantData_o,
  input  logic                      grantAck_i,
  output logic [CountBits-1:0]      freeCount_o
);

  import renameMsgPkg::*;

  logic        allocValid;
  logic        allocReady;
  allocReq_t   allocMsg;
  logic        relValid;
  releaseReq_t relMsg;
  logic        sourceIdle;
  logic        loadGrant;
  grant_t      grantMsg;

  fourPhaseSink #(.payload_t(allocReq_t)) allocSink0 (
    .clk      (clk),
    .reset    (reset),
    .req_i    (allocReq_i),
    .data_i   (allocData_i),
    .ack_o    (allocAck_o),
    .valid_o  (allocValid),
    .payload_o(allocMsg),
    .ready_i  (allocReady)
  );

  // releases never wait
  fourPhaseSink #(.payload_t(releaseReq_t)) relSink0 (
    .clk      (clk),
    .reset    (reset),
    .req_i    (relReq_i),
    .data_i   (relData_i),
    .ack_o    (relAck_o),
    .valid_o  (relValid),
    .payload_o(relMsg),
    .ready_i  (1'b1)
  );

  specFreeList #(
    .NumPhysRegs(NumPhysRegs),
    .NumArchRegs(NumArchRegs)
  ) freeList0 (
    .clk         (clk),
    .reset       (reset),
    .allocValid_i(allocValid),
    .alloc_i     (allocMsg),
    .allocReady_o(allocReady),
    .relValid_i  (relValid),
    .rel_i       (relMsg),
    .sourceIdle_i(sourceIdle),
    .recover_i   (recover_i),
    .loadGrant_o (loadGrant),
    .grant_o     (grantMsg),
    .freeCount_o (freeCount_o)
  );

  fourPhaseSource grantSource0 (
    .clk   (clk),
    .reset (reset),
    .load_i(loadGrant),
    .data_i(grantMsg),
    .idle_o(sourceIdle),
    .req_o (grantReq_o),
    .data_o(grantData_o),
    .ack_i (grantAck_i)
  );

endmodule

/* hw/specFreeList.sv */
// speculative circular free list of physical tags with one checkpoint and recovery
module specFreeList #(
  parameter int  NumPhysRegs = 48,
  parameter int  NumArchRegs = 16,
  localparam int ListSize = NumPhysRegs - NumArchRegs,
  localparam int CountBits = $clog2(ListSize + 1)
) (
  input  logic                      clk,
  input  logic                      reset,
  input  logic                      allocValid_i,
  input  renameMsgPkg::allocReq_t   alloc_i,
  output logic                      allocReady_o,
  input  logic                      relValid_i,
  input  renameMsgPkg::releaseReq_t rel_i,
  input  logic                      sourceIdle_i,
  input  logic                      recover_i,
  output logic                      loadGrant_o,
  output renameMsgPkg::grant_t      grant_o,
  output logic [CountBits-1:0]      freeCount_o
);

  import renameCfgPkg::*;
  import renameMsgPkg::*;

  localparam int IdxBits = $clog2(ListSize);

  typedef logic [IdxBits-1:0] listIdx_t;

  listIdx_t                 head;
  listIdx_t                 tail;
  listIdx_t                 nextHead;
  listIdx_t                 nextTail;
  logic [CountBits-1:0]     count;
  logic [CountBits-1:0]     nextCount;
  logic [CountBits-1:0]     recoverCount;
  logic                     cpValid;
  listIdx_t                 cpHead;
  listIdx_t                 cpTail;
  logic [CountBits-1:0]     cpCount;
  logic                     allocAccept;
  logic [LaneCountBits-1:0] popNum;
  logic [LaneCountBits-1:0] pushNum;
  listIdx_t [MaxLanes-1:0]  rdAddr;
  listIdx_t [MaxLanes-1:0]  wrAddr;
  logic [MaxLanes-1:0]      wrEn;
  physTag_t [MaxLanes-1:0]  rdTag;
  physTag_t [MaxLanes-1:0]  wrTag;

  // moves a list index forward by less than one lap
  function automatic listIdx_t advance(listIdx_t base, logic [31:0] step);
    logic [31:0] sum;
    sum = 32'(base) + step;
    if (sum >= 32'(ListSize))
      sum = sum - 32'(ListSize);
    return listIdx_t'(sum);
  endfunction

  freeListRam #(
    .NumPhysRegs(NumPhysRegs),
    .NumArchRegs(NumArchRegs)
  ) ram0 (
    .clk     (clk),
    .reset   (reset),
    .rdAddr_i(rdAddr),
    .rdTag_o (rdTag),
    .wrEn_i  (wrEn),
    .wrAddr_i(wrAddr),
    .wrTag_i (wrTag)
  );

  always_comb
  begin
    int slot;
    slot = 0;
    wrEn = '0;
    wrTag = '0;
    for (int l = 0; l < MaxLanes; l++)
    begin
      rdAddr[l] = advance(head, 32'(l));
      wrAddr[l] = advance(tail, 32'(l));
      // sparse release lanes fill consecutive write ports in lane order
      if (relValid_i && rel_i.valid[l])
      begin
        wrEn[slot] = 1'b1;
        wrTag[slot] = rel_i.tags[l];
        slot++;
      end
    end
    pushNum = LaneCountBits'(slot);
  end

  assign allocReady_o = (count >= CountBits'(alloc_i.count)) && sourceIdle_i && !recover_i;
  assign allocAccept = allocValid_i && allocReady_o;
  assign loadGrant_o = allocAccept;
  assign popNum = allocAccept ? alloc_i.count : '0;

  assign nextHead = advance(head, 32'(popNum));
  assign nextTail = advance(tail, 32'(pushNum));
  assign nextCount = count - CountBits'(popNum) + CountBits'(pushNum);
  assign freeCount_o = count;

  // tags returned since the checkpoint equal the distance the tail has moved
  always_comb
  begin
    logic [31:0] pushed;
    pushed = 32'(nextTail) + 32'(ListSize) - 32'(cpTail);
    if (pushed >= 32'(ListSize))
      pushed = pushed - 32'(ListSize);
    recoverCount = cpCount + CountBits'(pushed);
  end

  always_comb
  begin
    for (int l = 0; l < MaxLanes; l++)
      grant_o.valid[l] = LaneCountBits'(l) < alloc_i.count;
    grant_o.tags = rdTag;
    grant_o.headIdx = TagBits'(head);
  end

  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      head <= '0;
      tail <= '0;
      count <= CountBits'(ListSize);
      cpValid <= 1'b0;
    end
    else
    begin
      tail <= nextTail;  // retire keeps returning tags during recovery
      if (recover_i && cpValid)
      begin
        head <= cpHead;
        count <= recoverCount;
        cpValid <= 1'b0;
      end
      else
      begin
        head <= nextHead;
        count <= nextCount;
        if (allocAccept && alloc_i.takeCheckpoint)
          cpValid <= 1'b1;
      end
    end
  end

  // state before this request's pop and push
  always_ff @(posedge clk)
  begin
    if (allocAccept && alloc_i.takeCheckpoint)
    begin
      cpHead <= head;
      cpCount <= count;
      cpTail <= tail;
    end
  end

endmodule

/* hw/freeListRam.sv */
// four-read four-write storage for the free tags, filled with the spare tags at reset
module freeListRam #(
  parameter int  NumPhysRegs = 48,
  parameter int  NumArchRegs = 16,
  localparam int ListSize = NumPhysRegs - NumArchRegs,
  localparam int IdxBits = $clog2(ListSize)
) (
  input  logic                                               clk,
  input  logic                                               reset,
  input  logic [renameCfgPkg::MaxLanes-1:0][IdxBits-1:0]     rdAddr_i,
  output renameCfgPkg::physTag_t [renameCfgPkg::MaxLanes-1:0] rdTag_o,
  input  logic [renameCfgPkg::MaxLanes-1:0]                  wrEn_i,
  input  logic [renameCfgPkg::MaxLanes-1:0][IdxBits-1:0]     wrAddr_i,
  input  renameCfgPkg::physTag_t [renameCfgPkg::MaxLanes-1:0] wrTag_i
);

  import renameCfgPkg::*;

  physTag_t mem [ListSize];

  always_comb
  begin
    for (int l = 0; l < MaxLanes; l++)
      rdTag_o[l] = mem[rdAddr_i[l]];
  end

  // the architectural tags are mapped at reset, so the list starts with the rest
  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      for (int k = 0; k < ListSize; k++)
        mem[k] <= physTag_t'(NumArchRegs + k);
    end
    else
    begin
      for (int l = 0; l < MaxLanes; l++)
        if (wrEn_i[l])
          mem[wrAddr_i[l]] <= wrTag_i[l];
    end
  end

endmodule

/* hw/fourPhaseSource.sv */
// four-phase handshake sender that holds a grant stable until the consumer lets go
module fourPhaseSource (
  input  logic                 clk,
  input  logic                 reset,
  input  logic                 load_i,
  input  renameMsgPkg::grant_t data_i,
  output logic                 idle_o,
  output logic                 req_o,
  output renameMsgPkg::grant_t data_o,
  input  logic                 ack_i
);

  typedef enum logic [1:0] {srcIdle, srcRequesting, srcWaitAckLow} sourceState_t;

  sourceState_t state;

  assign idle_o = (state == srcIdle);

  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      state <= srcIdle;
      req_o <= 1'b0;
    end
    else
    begin
      case (state)
        srcIdle:
          if (load_i)
            state <= srcRequesting;
        srcRequesting:
          if (!req_o)
            req_o <= 1'b1;  // one edge after the grant was loaded
          else if (ack_i)
          begin
            req_o <= 1'b0;
            state <= srcWaitAckLow;
          end
        srcWaitAckLow:
          if (!ack_i)
            state <= srcIdle;
        default:
          state <= srcIdle;
      endcase
    end
  end

  always_ff @(posedge clk)
  begin
    if (idle_o && load_i)
      data_o <= data_i;
  end

endmodule

/* hw/fourPhaseSink.sv */
// four-phase handshake receiver that offers a request to the core with valid/ready
module fourPhaseSink #(
  parameter type payload_t = logic
) (
  input  logic     clk,
  input  logic     reset,
  input  logic     req_i,
  input  payload_t data_i,
  output logic     ack_o,
  output logic     valid_o,
  output payload_t payload_o,
  input  logic     ready_i
);

  typedef enum logic {sinkIdle, sinkAcked} sinkState_t;

  sinkState_t state;
  payload_t   heldPayload;

  // the core judges the request in the cycle it shows up, so capture and acceptance coincide
  assign valid_o = (state == sinkIdle) && req_i;
  assign payload_o = (state == sinkIdle) ? data_i : heldPayload;
  assign ack_o = (state == sinkAcked);

  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      state <= sinkIdle;
    end
    else
    begin
      case (state)
        sinkIdle:
          if (req_i && ready_i)
            state <= sinkAcked;  // back-pressure just leaves req waiting
        sinkAcked:
          if (!req_i)
            state <= sinkIdle;
        default:
          state <= sinkIdle;
      endcase
    end
  end

  always_ff @(posedge clk)
  begin
    if (valid_o && ready_i)
      heldPayload <= data_i;
  end

endmodule

/* hw/renameMsgPkg.sv */
// message formats carried on the allocate, release and grant handshakes
package renameMsgPkg;

  import renameCfgPkg::*;

  typedef struct packed {
    logic [LaneCountBits-1:0] count;  // tags wanted, 0 to MaxLanes
    logic                     takeCheckpoint;
  } allocReq_t;

  // tags come back from retire with a lane mask, holes allowed
  typedef struct packed {
    logic [MaxLanes-1:0]     valid;
    physTag_t [MaxLanes-1:0] tags;
  } releaseReq_t;

  typedef struct packed {
    logic [MaxLanes-1:0]     valid;  // low count bits set
    physTag_t [MaxLanes-1:0] tags;
    logic [TagBits-1:0]      headIdx;  // list slot of tags[0]
  } grant_t;

endpackage

/* hw/renameCfgPkg.sv */
// rename geometry: lanes per request, tag width and the physical tag type
package renameCfgPkg;

  // tags handed out or returned by one request
  localparam int MaxLanes = 4;

  // wide enough for up to 64 physical registers
  localparam int TagBits = 6;

  // holds a lane count from 0 to MaxLanes
  localparam int LaneCountBits = 3;

  typedef logic [TagBits-1:0] physTag_t;

endpackage
